// File: pc_io_pkg.sv
package pc_io_pkg;

	localparam int io_addr_w = 16;

	// Port window bases.
	localparam logic [io_addr_w-1:0] port_ide0       = 16'h01F0;
	localparam logic [io_addr_w-1:0] port_ide0_ctl   = 16'h03F6;
	localparam logic [io_addr_w-1:0] port_ide1       = 16'h0170;
	localparam logic [io_addr_w-1:0] port_ide1_ctl   = 16'h0376;
	localparam logic [io_addr_w-1:0] port_fdd        = 16'h03F0;
	localparam logic [io_addr_w-1:0] port_fdd_b      = 16'h03F4;
	localparam logic [io_addr_w-1:0] port_fdd_c      = 16'h03F7;
	localparam logic [io_addr_w-1:0] port_dma_master = 16'h00C0;
	localparam logic [io_addr_w-1:0] port_dma_page   = 16'h0080;
	localparam logic [io_addr_w-1:0] port_dma_slave  = 16'h0000;
	localparam logic [io_addr_w-1:0] port_pic_master = 16'h0020;
	localparam logic [io_addr_w-1:0] port_pic_slave  = 16'h00A0;
	localparam logic [io_addr_w-1:0] port_pit        = 16'h0040;
	localparam logic [io_addr_w-1:0] port_pit_spk    = 16'h0061;
	localparam logic [io_addr_w-1:0] port_ps2_io     = 16'h0060;
	localparam logic [io_addr_w-1:0] port_ps2_ctl    = 16'h0090;
	localparam logic [io_addr_w-1:0] port_rtc        = 16'h0070;
	localparam logic [io_addr_w-1:0] port_fm         = 16'h0388;
	localparam logic [io_addr_w-1:0] port_sb         = 16'h0220;
	localparam logic [io_addr_w-1:0] port_uart1      = 16'h03F8;
	localparam logic [io_addr_w-1:0] port_uart2      = 16'h02F8;
	localparam logic [io_addr_w-1:0] port_mpu        = 16'h0330;
	localparam logic [io_addr_w-1:0] port_vga_b      = 16'h03B0;
	localparam logic [io_addr_w-1:0] port_vga_c      = 16'h03C0;
	localparam logic [io_addr_w-1:0] port_vga_d      = 16'h03D0;
	localparam logic [io_addr_w-1:0] port_joy        = 16'h0201;
	localparam logic [io_addr_w-1:0] port_sysctl     = 16'h8888;

	// Low address bits ignored per window. Single ports compare exactly.
	localparam int span_ide      = 3;
	localparam int span_fdd      = 2;
	localparam int span_fdd_b    = 1;
	localparam int span_dma_mst  = 5;
	localparam int span_dma      = 4;
	localparam int span_pic      = 1;
	localparam int span_pit      = 2;
	localparam int span_ps2_io   = 3;
	localparam int span_ps2_ctl  = 4;
	localparam int span_rtc      = 1;
	localparam int span_fm       = 2;
	localparam int span_sb       = 4;
	localparam int span_uart     = 3;
	localparam int span_mpu      = 1;
	localparam int span_vga      = 4;

	localparam logic [2:0] io_size_word = 3'd2;
	localparam logic [7:0] sysctl_key   = 8'hA1;
	localparam logic [7:0] syscfg_reset = 8'hA2;

	// Upper byte of a management address.
	localparam logic [7:0] mgmt_tgt_ide0 = 8'hF0;
	localparam logic [7:0] mgmt_tgt_ide1 = 8'hF1;
	localparam logic [7:0] mgmt_tgt_fdd  = 8'hF2;
	localparam logic [7:0] mgmt_tgt_rtc  = 8'hF4;

	typedef struct packed {
		logic [15:0] unused;
		logic [7:0]  key;
		logic [7:0]  value;
	} sysctl_word_t;

	typedef union packed {
		logic [31:0]  raw;
		sysctl_word_t sysctl; // Control port view.
	} io_wdata_u;

	typedef struct packed {
		logic [io_addr_w-1:0] address;
		logic                 read;
		logic                 write;
		logic [2:0]           datasize;
		io_wdata_u            writedata;
	} io_bus_t;

	typedef struct packed {
		logic ide0, ide1, floppy;
		logic dma_master, dma_page, dma_slave;
		logic pic_master, pic_slave;
		logic pit, ps2_io, ps2_ctl, rtc;
		logic fm, sb, uart1, uart2, mpu;
		logic vga_b, vga_c, vga_d;
		logic joy, sysctl;
	} io_sel_t;

	typedef struct packed {
		logic [7:0] floppy, dma, pic, pit;
		logic [7:0] ps2, rtc, sound, uart1;
		logic [7:0] uart2, mpu, vga, joy;
	} dev_rdata_t;

	typedef struct packed {
		logic [15:0] address;
		logic        read;
		logic        write;
	} mgmt_req_t;

	typedef struct packed {
		logic ide0_rd, ide0_wr;
		logic ide1_rd, ide1_wr;
		logic fdd_rd, fdd_wr;
		logic rtc_rd, rtc_wr;
	} mgmt_strb_t;

endpackage

// File: io_port_decode.sv
`timescale 1ns/1ps

module io_port_decode (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  pc_io_pkg::io_bus_t   bus,
	output pc_io_pkg::io_sel_t   sel
);
	import pc_io_pkg::*;

	logic [io_addr_w-1:0] addr;
	io_sel_t              sel_nxt;

	// Address falls in a window of 2**span ports at base.
	function automatic logic in_win(input logic [io_addr_w-1:0] a,
			input logic [io_addr_w-1:0] base, input int span);
		logic [io_addr_w-1:0] mask;
		mask = '1 << span;
		return (a & mask) == base;
	endfunction

	assign addr = bus.address;

	always_comb begin
		sel_nxt = '0;
		sel_nxt.ide0       = in_win(addr, port_ide0, span_ide) || addr == port_ide0_ctl;
		sel_nxt.ide1       = in_win(addr, port_ide1, span_ide) || addr == port_ide1_ctl;
		sel_nxt.floppy     = in_win(addr, port_fdd, span_fdd) ||
		                     in_win(addr, port_fdd_b, span_fdd_b) ||
		                     addr == port_fdd_c; // 3F6h belongs to ide0.
		sel_nxt.dma_master = in_win(addr, port_dma_master, span_dma_mst);
		sel_nxt.dma_page   = in_win(addr, port_dma_page, span_dma);
		sel_nxt.dma_slave  = in_win(addr, port_dma_slave, span_dma);
		sel_nxt.pic_master = in_win(addr, port_pic_master, span_pic);
		sel_nxt.pic_slave  = in_win(addr, port_pic_slave, span_pic);
		sel_nxt.pit        = in_win(addr, port_pit, span_pit) || addr == port_pit_spk;
		sel_nxt.ps2_io     = in_win(addr, port_ps2_io, span_ps2_io);
		sel_nxt.ps2_ctl    = in_win(addr, port_ps2_ctl, span_ps2_ctl);
		sel_nxt.rtc        = in_win(addr, port_rtc, span_rtc);
		sel_nxt.fm         = in_win(addr, port_fm, span_fm);
		sel_nxt.sb         = in_win(addr, port_sb, span_sb);
		sel_nxt.uart1      = in_win(addr, port_uart1, span_uart);
		sel_nxt.uart2      = in_win(addr, port_uart2, span_uart);
		sel_nxt.mpu        = in_win(addr, port_mpu, span_mpu);
		sel_nxt.vga_b      = in_win(addr, port_vga_b, span_vga);
		sel_nxt.vga_c      = in_win(addr, port_vga_c, span_vga);
		sel_nxt.vga_d      = in_win(addr, port_vga_d, span_vga);
		sel_nxt.joy        = addr == port_joy;
		sel_nxt.sysctl     = addr == port_sysctl;
	end

	// One cycle from address to select.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel <= '0;
		end else begin
			sel <= sel_nxt;
		end
	end

endmodule

// File: sys_ctl_port.sv
`timescale 1ns/1ps

module sys_ctl_port (
	input  logic               clk_sys,
	input  logic               reset,
	input  pc_io_pkg::io_bus_t bus,
	input  pc_io_pkg::io_sel_t sel,
	output logic [7:0]         syscfg
);
	import pc_io_pkg::*;

	logic in_reset; // Set until the first disk access or keyed write.
	logic disk_hit;
	logic key_ok;

	assign disk_hit = sel.ide0 | sel.ide1 | sel.floppy;

	// Keyed 16-bit write to the control port.
	assign key_ok = bus.write && sel.sysctl && bus.datasize == io_size_word &&
	                bus.writedata.sysctl.key == sysctl_key;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg   <= syscfg_reset;
			in_reset <= 1'b1;
		end else if (disk_hit && in_reset) begin
			syscfg   <= '0; // Boot has reached the disks.
			in_reset <= 1'b0;
		end else if (key_ok) begin
			syscfg   <= bus.writedata.sysctl.value;
			in_reset <= 1'b0;
		end
	end

endmodule

// File: io_read_mux.sv
`timescale 1ns/1ps

module io_read_mux (
	input  pc_io_pkg::io_bus_t    bus,
	input  pc_io_pkg::io_sel_t    sel,
	input  pc_io_pkg::dev_rdata_t dev_rdata,
	input  logic [31:0]           ide0_rdata,
	input  logic [31:0]           ide1_rdata,
	output logic [31:0]           bus_readdata,
	output logic                  bus_io32
);
	import pc_io_pkg::*;

	logic [7:0] rdata8;

	// Byte devices, first match wins.
	always_comb begin
		if (sel.floppy) begin
			rdata8 = dev_rdata.floppy;
		end else if (sel.dma_master | sel.dma_slave | sel.dma_page) begin
			rdata8 = dev_rdata.dma;
		end else if (sel.pic_master | sel.pic_slave) begin
			rdata8 = dev_rdata.pic;
		end else if (sel.pit) begin
			rdata8 = dev_rdata.pit;
		end else if (sel.ps2_io | sel.ps2_ctl) begin
			rdata8 = dev_rdata.ps2;
		end else if (sel.rtc) begin
			rdata8 = dev_rdata.rtc;
		end else if (sel.sb | sel.fm) begin
			rdata8 = dev_rdata.sound;
		end else if (sel.uart1) begin
			rdata8 = dev_rdata.uart1;
		end else if (sel.uart2) begin
			rdata8 = dev_rdata.uart2;
		end else if (sel.mpu) begin
			rdata8 = dev_rdata.mpu;
		end else if (sel.vga_b | sel.vga_c | sel.vga_d) begin
			rdata8 = dev_rdata.vga;
		end else if (sel.joy) begin
			rdata8 = dev_rdata.joy;
		end else begin
			rdata8 = 8'hFF; // Open bus.
		end
	end

	assign bus_readdata = sel.ide0 ? ide0_rdata :
	                      sel.ide1 ? ide1_rdata :
	                      {24'h0, rdata8};

	// IDE data port is 32-bit, its control port at 3x6h is not.
	assign bus_io32 = ((sel.ide0 | sel.ide1) & ~bus.address[9]) | sel.sysctl;

endmodule

// File: mgmt_decode.sv
`timescale 1ns/1ps

module mgmt_decode (
	input  pc_io_pkg::mgmt_req_t  mgmt,
	input  logic [15:0]           mgmt_ide0_rdata,
	input  logic [15:0]           mgmt_ide1_rdata,
	input  logic [15:0]           mgmt_fdd_rdata,
	output pc_io_pkg::mgmt_strb_t mgmt_strb,
	output logic [15:0]           mgmt_readdata
);
	import pc_io_pkg::*;

	logic [7:0] tgt;
	logic       hit_ide0;
	logic       hit_ide1;
	logic       hit_fdd;
	logic       hit_rtc;

	assign tgt      = mgmt.address[15:8];
	assign hit_ide0 = tgt == mgmt_tgt_ide0;
	assign hit_ide1 = tgt == mgmt_tgt_ide1;
	assign hit_fdd  = tgt == mgmt_tgt_fdd;
	assign hit_rtc  = tgt == mgmt_tgt_rtc;

	assign mgmt_strb.ide0_rd = mgmt.read & hit_ide0;
	assign mgmt_strb.ide0_wr = mgmt.write & hit_ide0;
	assign mgmt_strb.ide1_rd = mgmt.read & hit_ide1;
	assign mgmt_strb.ide1_wr = mgmt.write & hit_ide1;
	assign mgmt_strb.fdd_rd  = mgmt.read & hit_fdd;
	assign mgmt_strb.fdd_wr  = mgmt.write & hit_fdd;
	assign mgmt_strb.rtc_rd  = mgmt.read & hit_rtc;
	assign mgmt_strb.rtc_wr  = mgmt.write & hit_rtc;

	// Floppy is the fallback source.
	assign mgmt_readdata = hit_ide0 ? mgmt_ide0_rdata :
	                       hit_ide1 ? mgmt_ide1_rdata :
	                       mgmt_fdd_rdata;

endmodule

// File: pc_io_glue.sv
`timescale 1ns/1ps

module pc_io_glue (
	input  logic                  clk_sys,
	input  logic                  reset,

	input  pc_io_pkg::io_bus_t    bus,
	input  pc_io_pkg::dev_rdata_t dev_rdata,
	input  logic [31:0]           ide0_rdata,
	input  logic [31:0]           ide1_rdata,

	input  pc_io_pkg::mgmt_req_t  mgmt,
	input  logic [15:0]           mgmt_ide0_rdata,
	input  logic [15:0]           mgmt_ide1_rdata,
	input  logic [15:0]           mgmt_fdd_rdata,

	output pc_io_pkg::io_sel_t    io_sel,
	output logic [31:0]           bus_readdata,
	output logic                  bus_io32,
	output logic [7:0]            syscfg,
	output pc_io_pkg::mgmt_strb_t mgmt_strb,
	output logic [15:0]           mgmt_readdata
);

	io_port_decode port_decode_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.sel          (io_sel)
	);

	sys_ctl_port sys_ctl_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.sel          (io_sel),
		.syscfg       (syscfg)
	);

	// Read data lines up with the registered selects.
	io_read_mux read_mux_i (
		.bus          (bus),
		.sel          (io_sel),
		.dev_rdata    (dev_rdata),
		.ide0_rdata   (ide0_rdata),
		.ide1_rdata   (ide1_rdata),
		.bus_readdata (bus_readdata),
		.bus_io32     (bus_io32)
	);

	mgmt_decode mgmt_decode_i (
		.mgmt            (mgmt),
		.mgmt_ide0_rdata (mgmt_ide0_rdata),
		.mgmt_ide1_rdata (mgmt_ide1_rdata),
		.mgmt_fdd_rdata  (mgmt_fdd_rdata),
		.mgmt_strb       (mgmt_strb),
		.mgmt_readdata   (mgmt_readdata)
	);

endmodule

// File: tb_pc_io_glue.sv
`timescale 1ns/1ps

module tb_pc_io_glue;
	import pc_io_pkg::*;

	logic        clk_sys;
	logic        reset;
	io_bus_t     bus;
	dev_rdata_t  dev_rdata;
	logic [31:0] ide0_rdata;
	logic [31:0] ide1_rdata;
	mgmt_req_t   mgmt;
	logic [15:0] mgmt_ide0_rdata, mgmt_ide1_rdata, mgmt_fdd_rdata;
	io_sel_t     io_sel;
	logic [31:0] bus_readdata;
	logic        bus_io32;
	logic [7:0]  syscfg;
	mgmt_strb_t  mgmt_strb;
	logic [15:0] mgmt_readdata;

	io_sel_t     m_sel; // Reference model state.
	logic [7:0]  m_syscfg;
	logic        m_fresh;
	logic [15:0] lfsr = 16'd28132;
	int          errors = 0;
	int          checks = 0;

	localparam logic [15:0] win_base [27] = '{16'h01F0, 16'h03F6, 16'h0170, 16'h0376,
		16'h03F0, 16'h03F4, 16'h03F7, 16'h00C0, 16'h0080, 16'h0000, 16'h0020, 16'h00A0,
		16'h0040, 16'h0061, 16'h0060, 16'h0090, 16'h0070, 16'h0388, 16'h0220, 16'h03F8,
		16'h02F8, 16'h0330, 16'h03B0, 16'h03C0, 16'h03D0, 16'h0201, 16'h8888};

	pc_io_glue dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Taps 16, 14, 13, 11.
	function automatic logic [31:0] lfsr_bits(input int nbits);
		logic [31:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < nbits; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic in_range(input logic [15:0] a, input logic [15:0] lo, input int n);
		return int'(a) >= int'(lo) && int'(a) < int'(lo) + n;
	endfunction

	function automatic io_sel_t model_sel(input logic [15:0] a);
		io_sel_t s;
		s.ide0       = in_range(a, 16'h01F0, 8) || a == 16'h03F6;
		s.ide1       = in_range(a, 16'h0170, 8) || a == 16'h0376;
		s.floppy     = in_range(a, 16'h03F0, 6) || a == 16'h03F7;
		s.dma_master = in_range(a, 16'h00C0, 32);
		s.dma_page   = in_range(a, 16'h0080, 16);
		s.dma_slave  = in_range(a, 16'h0000, 16);
		s.pic_master = in_range(a, 16'h0020, 2);
		s.pic_slave  = in_range(a, 16'h00A0, 2);
		s.pit        = in_range(a, 16'h0040, 4) || a == 16'h0061;
		s.ps2_io     = in_range(a, 16'h0060, 8);
		s.ps2_ctl    = in_range(a, 16'h0090, 16);
		s.rtc        = in_range(a, 16'h0070, 2);
		s.fm         = in_range(a, 16'h0388, 4);
		s.sb         = in_range(a, 16'h0220, 16);
		s.uart1      = in_range(a, 16'h03F8, 8);
		s.uart2      = in_range(a, 16'h02F8, 8);
		s.mpu        = in_range(a, 16'h0330, 2);
		s.vga_b      = in_range(a, 16'h03B0, 16);
		s.vga_c      = in_range(a, 16'h03C0, 16);
		s.vga_d      = in_range(a, 16'h03D0, 16);
		s.joy        = a == 16'h0201;
		s.sysctl     = a == 16'h8888;
		return s;
	endfunction

	// Lowest priority first, later matches overwrite.
	function automatic logic [31:0] model_rdata(input io_sel_t s);
		logic [7:0] b;
		b = 8'hFF;
		if (s.joy) b = dev_rdata.joy;
		if (s.vga_b | s.vga_c | s.vga_d) b = dev_rdata.vga;
		if (s.mpu) b = dev_rdata.mpu;
		if (s.uart2) b = dev_rdata.uart2;
		if (s.uart1) b = dev_rdata.uart1;
		if (s.sb | s.fm) b = dev_rdata.sound;
		if (s.rtc) b = dev_rdata.rtc;
		if (s.ps2_io | s.ps2_ctl) b = dev_rdata.ps2;
		if (s.pit) b = dev_rdata.pit;
		if (s.pic_master | s.pic_slave) b = dev_rdata.pic;
		if (s.dma_master | s.dma_page | s.dma_slave) b = dev_rdata.dma;
		if (s.floppy) b = dev_rdata.floppy;
		return s.ide0 ? ide0_rdata : s.ide1 ? ide1_rdata : {24'h0, b};
	endfunction

	// IDE data windows and the control port are the 32-bit ports.
	function automatic logic model_io32(input io_sel_t s, input logic [15:0] a);
		return (s.ide0 && in_range(a, 16'h01F0, 8)) || (s.ide1 && in_range(a, 16'h0170, 8)) ||
		       s.sysctl;
	endfunction

	function automatic mgmt_strb_t model_strb(input mgmt_req_t m);
		mgmt_strb_t s;
		s = '0;
		case (m.address[15:8])
			8'hF0: {s.ide0_rd, s.ide0_wr} = {m.read, m.write};
			8'hF1: {s.ide1_rd, s.ide1_wr} = {m.read, m.write};
			8'hF2: {s.fdd_rd, s.fdd_wr} = {m.read, m.write};
			8'hF4: {s.rtc_rd, s.rtc_wr} = {m.read, m.write};
			default: ;
		endcase
		return s;
	endfunction

	function automatic logic [15:0] model_mgmt_rdata(input logic [7:0] tgt);
		logic [15:0] d;
		case (tgt)
			8'hF0:   d = mgmt_ide0_rdata;
			8'hF1:   d = mgmt_ide1_rdata;
			default: d = mgmt_fdd_rdata;
		endcase
		return d;
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			m_sel    <= '0;
			m_syscfg <= 8'hA2;
			m_fresh  <= 1'b1;
		end else begin
			m_sel <= model_sel(bus.address);
			if (m_fresh && (m_sel.ide0 | m_sel.ide1 | m_sel.floppy)) begin
				m_syscfg <= 8'h00;
				m_fresh  <= 1'b0;
			end else if (bus.write && m_sel.sysctl && bus.datasize == 3'd2 &&
			             bus.writedata.sysctl.key == 8'hA1) begin
				m_syscfg <= bus.writedata.sysctl.value;
				m_fresh  <= 1'b0;
			end
		end
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One cycle, then compare every output with the model.
	task automatic step();
		@(negedge clk_sys);
		check_eq(32'(io_sel), 32'(m_sel), "io_sel");
		check_eq(32'(syscfg), 32'(m_syscfg), "syscfg");
		check_eq(bus_readdata, model_rdata(m_sel), "bus_readdata");
		check_eq(32'(bus_io32), 32'(model_io32(m_sel, bus.address)), "bus_io32");
		check_eq(32'(mgmt_strb), 32'(model_strb(mgmt)), "mgmt_strb");
		check_eq(32'(mgmt_readdata), 32'(model_mgmt_rdata(mgmt.address[15:8])),
			"mgmt_readdata");
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) step();
		reset = 1'b0;
	endtask

	task automatic randomize_inputs();
		logic [7:0] hi;
		dev_rdata       = {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32)};
		ide0_rdata      = lfsr_bits(32);
		ide1_rdata      = lfsr_bits(32);
		hi              = lfsr_bits(1) != 0 ? 8'(8'hF0 | lfsr_bits(3)) : 8'(lfsr_bits(8));
		mgmt.address    = {hi, 8'(lfsr_bits(8))};
		mgmt.read       = 1'(lfsr_bits(1));
		mgmt.write      = 1'(lfsr_bits(1));
		mgmt_ide0_rdata = 16'(lfsr_bits(16));
		mgmt_ide1_rdata = 16'(lfsr_bits(16));
		mgmt_fdd_rdata  = 16'(lfsr_bits(16));
	endtask

	// Address first, write strobe one cycle later.
	task automatic bus_write(input logic [15:0] a, input logic [2:0] size,
			input logic [7:0] key, input logic [7:0] value);
		bus.address = a;
		step();
		bus.write                  = 1'b1;
		bus.datasize               = size;
		bus.writedata.sysctl.key   = key;
		bus.writedata.sysctl.value = value;
		step();
		bus.write = 1'b0;
		step();
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	task automatic wait_syscfg(input logic [7:0] want, input int limit);
		int n;
		n = 0;
		while (syscfg !== want && n < limit) begin
			step();
			n++;
		end
		if (syscfg !== want) begin
			errors++;
			$display("Timeout: syscfg did not reach %h within %0d cycles", want, limit);
		end
	endtask

	initial begin
		logic [15:0] a;
		logic [2:0]  sz;
		logic [7:0]  k;
		int          i;
		reset           = 1'b1;
		bus             = '0;
		bus.address     = 16'h0500; // Unmapped.
		dev_rdata       = '0;
		ide0_rdata      = '0;
		ide1_rdata      = '0;
		mgmt            = '0;
		mgmt_ide0_rdata = '0;
		mgmt_ide1_rdata = '0;
		mgmt_fdd_rdata  = '0;
		apply_reset();
		step();
		check_eq(32'(io_sel), 32'h0, "io_sel after reset");
		check_eq(32'(syscfg), 32'hA2, "syscfg after reset");
		check_eq(bus_readdata, 32'hFF, "unmapped read");

		for (i = 0; i < 400; i++) begin
			a = lfsr_bits(1) != 0 ? 16'(win_base[lfsr_bits(5) % 27] + lfsr_bits(3)) :
			    16'(lfsr_bits(16));
			bus.address = a;
			bus.read    = 1'(lfsr_bits(1));
			randomize_inputs();
			step();
			step();
		end

		bus.address = 16'h0500;
		apply_reset();
		check_eq(32'(syscfg), 32'hA2, "syscfg after second reset");
		bus.address = 16'h03F7;
		wait_syscfg(8'h00, 4);
		bus_write(16'h8888, 3'd2, 8'hA1, 8'h5A);
		check_eq(32'(syscfg), 32'h5A, "syscfg after keyed write");
		bus.address = 16'h01F3;
		step();
		step();
		check_eq(32'(syscfg), 32'h5A, "syscfg after later disk access");

		for (i = 0; i < 80; i++) begin
			a  = lfsr_bits(2) != 0 ? 16'h8888 : 16'(lfsr_bits(16));
			sz = lfsr_bits(1) != 0 ? 3'd2 : 3'(lfsr_bits(3));
			k  = lfsr_bits(1) != 0 ? 8'hA1 : 8'(lfsr_bits(8));
			bus_write(a, sz, k, 8'(lfsr_bits(8)));
		end
		finish_run();
	end

endmodule

// File: compile.f
pc_io_pkg.sv
io_port_decode.sv
sys_ctl_port.sv
io_read_mux.sv
mgmt_decode.sv
pc_io_glue.sv
tb_pc_io_glue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_pc_io_glue
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
